//--- design/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  // address split is tag | index | byte offset
  localparam int addr_w   = 16;
  localparam int tag_w    = 8;
  localparam int index_w  = 5;
  localparam int offset_w = 3;
  localparam int lines    = 32;

  localparam int line_w         = 64;
  localparam int word_w         = 32;
  localparam int bytes_per_line = line_w / 8;

  // miss-status queue
  localparam int mshr_depth = 8;
  localparam int mshr_ptr_w = 3;

  // controller tags, zero means no response
  localparam int mem_tag_w = 4;

  typedef enum logic [1:0] {
    BUS_NONE  = 2'd0,
    BUS_LOAD  = 2'd1,
    BUS_STORE = 2'd2
  } bus_command_e;

  // one cache line, seen as two words or as eight bytes
  // word view for lane select, byte view for masked merge
  typedef union packed {
    logic [1:0][word_w-1:0]         words;
    logic [bytes_per_line-1:0][7:0] bytes;
  } cache_line_u;

endpackage

`default_nettype wire

//--- design/dcache_array.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_array import dcache_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  // load lookup
  input  logic [addr_w-1:0]     load_addr,
  output cache_line_u           rd_line,
  output logic                  rd_valid,
  // store port
  input  logic                  store_valid,
  input  logic [addr_w-1:0]     store_addr,
  input  logic [word_w-1:0]     store_data,
  input  logic [word_w/8-1:0]   store_bytes,
  output logic                  store_miss,
  output cache_line_u           store_line,
  output logic [bytes_per_line-1:0] store_mask,
  // refill from the miss queue
  input  logic                  refill_valid,
  input  logic [index_w-1:0]    refill_index,
  input  logic [tag_w-1:0]      refill_tag,
  input  cache_line_u           refill_line,
  input  logic                  refill_dirty,
  // dirty line pushed out by the refill
  output logic                  victim_valid,
  output logic [addr_w-1:0]     victim_addr,
  output cache_line_u           victim_line
);

  logic [tag_w-1:0] tag_mem [lines];
  cache_line_u      data_mem [lines];
  logic [lines-1:0] valid;
  logic [lines-1:0] dirty;

  logic [index_w-1:0] ld_index;
  logic [tag_w-1:0]   ld_tag;
  logic [index_w-1:0] st_index;
  logic [tag_w-1:0]   st_tag;
  logic               st_present;
  logic               store_hit;
  logic               refill_keep;

  assign {ld_tag, ld_index} = load_addr[addr_w-1:offset_w];
  assign {st_tag, st_index} = store_addr[addr_w-1:offset_w];

  assign rd_line  = data_mem[ld_index];
  assign rd_valid = valid[ld_index] && (tag_mem[ld_index] == ld_tag);

  // place the word and its mask in the half picked by addr bit 2
  always_comb begin
    store_line = '0;
    store_line.words[store_addr[offset_w-1]] = store_data;
    if (store_addr[offset_w-1]) begin
      store_mask = {store_bytes, {(word_w/8){1'b0}}};
    end else begin
      store_mask = {{(word_w/8){1'b0}}, store_bytes};
    end
  end

  assign st_present = valid[st_index] && (tag_mem[st_index] == st_tag);

  // a store into the line being refilled goes to the queue instead
  assign store_hit  = store_valid && st_present &&
                      !(refill_valid && (refill_index == st_index));
  assign store_miss = store_valid && !store_hit;

  // line already holds this block (duplicate load miss), keep the newer copy
  assign refill_keep = valid[refill_index] && (tag_mem[refill_index] == refill_tag) &&
                       !refill_dirty;

  assign victim_valid = refill_valid && valid[refill_index] && dirty[refill_index] &&
                        (tag_mem[refill_index] != refill_tag);
  assign victim_line  = data_mem[refill_index];
  assign victim_addr  = {tag_mem[refill_index], refill_index, {offset_w{1'b0}}};

  // tag and data storage
  always_ff @(posedge clock) begin
    if (store_hit) begin
      for (int j = 0; j < bytes_per_line; j++) begin
        if (store_mask[j]) data_mem[st_index].bytes[j] <= store_line.bytes[j];
      end
    end
    if (refill_valid) begin
      tag_mem[refill_index] <= refill_tag;
      if (!refill_keep) data_mem[refill_index] <= refill_line;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;  // every line invalid after reset
      dirty <= '0;
    end else begin
      if (store_hit) dirty[st_index] <= 1'b1;
      if (refill_valid) begin
        valid[refill_index] <= 1'b1;
        if (!refill_keep) dirty[refill_index] <= refill_dirty;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/dcache_load_port.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_load_port import dcache_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  // core load request
  input  logic                  load_start,
  input  logic [addr_w-1:0]     load_addr,
  // array lookup result
  input  cache_line_u           rd_line,
  input  logic                  rd_valid,
  // from the miss queue
  input  logic [mshr_depth-1:0] pending_store_hit,
  input  logic                  retire_load,
  input  cache_line_u           retire_line,
  input  logic                  retire_offset,
  // to the core
  output logic                  load_hit,
  output logic [word_w-1:0]     load_data,
  output logic                  load_miss,
  output logic                  broadcast_valid,
  output logic [word_w-1:0]     broadcast_data
);

  // entries holding a store miss to the block of the waiting load
  logic [mshr_depth-1:0] hazard_q;
  logic                  hazard;

  // capture at start, then only ever shrink as those entries retire
  always_ff @(posedge clock) begin
    if (reset) begin
      hazard_q <= '0;
    end else if (load_start) begin
      hazard_q <= pending_store_hit;
    end else begin
      hazard_q <= hazard_q & pending_store_hit;
    end
  end

  // on the start cycle the register is not loaded yet
  assign hazard = load_start ? |pending_store_hit : |hazard_q;

  assign load_data = rd_line.words[load_addr[offset_w-1]];  // bit 2 picks the word
  assign load_hit  = rd_valid && !hazard;

  // blocked loads wait for the store miss and are not queued
  assign load_miss = load_start && !rd_valid && !hazard;

  // completion of a queued load, in the refill cycle
  assign broadcast_valid = retire_load;
  assign broadcast_data  = retire_line.words[retire_offset];

endmodule

`default_nettype wire

//--- design/dcache_miss_queue.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_miss_queue import dcache_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  // new misses
  input  logic                  load_miss,
  input  logic [addr_w-1:0]     load_addr,
  input  logic                  store_miss,
  input  logic [addr_w-1:0]     store_addr,
  input  cache_line_u           store_line,
  input  logic [bytes_per_line-1:0] store_mask,
  input  logic                  victim_valid,
  input  logic [addr_w-1:0]     victim_addr,
  input  cache_line_u           victim_line,
  // controller responses
  input  logic [mem_tag_w-1:0]  mem_response,
  input  logic [line_w-1:0]     mem_resp_data,
  input  logic [mem_tag_w-1:0]  mem_resp_tag,
  // status
  output logic [mshr_depth-1:0] pending_store_hit,
  output logic                  load_stall,
  output logic                  store_stall,
  // refill into the array
  output logic                  refill_valid,
  output logic [index_w-1:0]    refill_index,
  output logic [tag_w-1:0]      refill_tag,
  output cache_line_u           refill_line,
  output logic                  refill_dirty,
  // completion toward the load port
  output logic                  retire_load,
  output cache_line_u           retire_line,
  output logic                  retire_offset,
  // controller commands
  output bus_command_e          mem_command,
  output logic [addr_w-1:0]     mem_addr,
  output logic [line_w-1:0]     mem_data
);

  // entry fields
  bus_command_e               ent_command [mshr_depth];  // BUS_NONE marks a free slot
  logic [addr_w-offset_w-1:0] ent_block   [mshr_depth];
  cache_line_u                ent_data    [mshr_depth];
  logic [bytes_per_line-1:0]  ent_mask    [mshr_depth];
  logic [mem_tag_w-1:0]       ent_tag     [mshr_depth];
  logic [mshr_depth-1:0]      ent_dirty;  // store miss waiting for its refill
  logic [mshr_depth-1:0]      ent_issued;
  logic [mshr_depth-1:0]      ent_offset;
  logic [mshr_depth-1:0]      ent_from_load;

  logic [mshr_ptr_w-1:0] head;
  logic [mshr_ptr_w-1:0] issue;
  logic [mshr_ptr_w-1:0] tail;
  logic [mshr_ptr_w:0]   count;  // occupied entries

  logic                  issue_ready;
  logic                  do_issue;
  logic                  retire_is_load;
  logic                  do_retire;
  logic                  alloc_load;
  logic                  alloc_store;
  logic                  alloc_wb;
  logic [mshr_ptr_w-1:0] slot_load;
  logic [mshr_ptr_w-1:0] slot_store;
  logic [mshr_ptr_w-1:0] slot_wb;
  cache_line_u           resp_line;

  assign resp_line = mem_resp_data;

  // retire at head
  assign retire_is_load = (ent_command[head] == BUS_LOAD) && ent_issued[head] &&
                          (mem_resp_tag != '0) && (mem_resp_tag == ent_tag[head]);
  assign do_retire      = retire_is_load ||
                          ((ent_command[head] == BUS_STORE) && ent_issued[head]);

  // store miss bytes win over the returned block
  always_comb begin
    refill_line = resp_line;
    if (ent_dirty[head]) begin
      for (int j = 0; j < bytes_per_line; j++) begin
        if (ent_mask[head][j]) refill_line.bytes[j] = ent_data[head].bytes[j];
      end
    end
  end

  assign refill_valid  = retire_is_load;
  assign refill_index  = ent_block[head][index_w-1:0];
  assign refill_tag    = ent_block[head][index_w +: tag_w];
  assign refill_dirty  = ent_dirty[head];
  assign retire_load   = retire_is_load && ent_from_load[head];
  assign retire_line   = refill_line;
  assign retire_offset = ent_offset[head];

  // issue; the entry stays on the bus until the controller takes it
  assign issue_ready = (ent_command[issue] != BUS_NONE) && !ent_issued[issue];
  assign do_issue    = issue_ready && (mem_response != '0);

  always_comb begin
    mem_command = BUS_NONE;
    mem_addr    = '0;
    mem_data    = '0;
    if (issue_ready) begin
      mem_command = ent_command[issue];
      mem_addr    = {ent_block[issue], {offset_w{1'b0}}};
      mem_data    = ent_data[issue];
    end
  end

  // one slot always held back for a writeback
  assign load_stall  = count > (mshr_ptr_w+1)'(mshr_depth - 2);
  assign store_stall = |ent_dirty || (count > (mshr_ptr_w+1)'(mshr_depth - 3));

  always_comb begin
    for (int i = 0; i < mshr_depth; i++) begin
      pending_store_hit[i] = ent_dirty[i] &&
                             (ent_block[i] == load_addr[addr_w-1:offset_w]);
    end
  end

  // allocation order is load, store, writeback
  assign alloc_load  = load_miss && !load_stall;
  assign alloc_store = store_miss && !store_stall;
  assign alloc_wb    = victim_valid;
  assign slot_load   = tail;
  assign slot_store  = slot_load + mshr_ptr_w'(alloc_load);
  assign slot_wb     = slot_store + mshr_ptr_w'(alloc_store);

  always_ff @(posedge clock) begin
    if (reset) begin
      head       <= '0;
      issue      <= '0;
      tail       <= '0;
      count      <= '0;
      ent_dirty  <= '0;
      ent_issued <= '0;
      for (int i = 0; i < mshr_depth; i++) ent_command[i] <= BUS_NONE;
    end else begin
      if (do_retire) begin
        ent_command[head] <= BUS_NONE;
        ent_issued[head]  <= 1'b0;
        ent_dirty[head]   <= 1'b0;
        head              <= head + 1'b1;
      end
      if (do_issue) begin
        ent_issued[issue] <= 1'b1;
        issue             <= issue + 1'b1;
      end
      if (alloc_load) begin
        ent_command[slot_load] <= BUS_LOAD;
        ent_issued[slot_load]  <= 1'b0;
        ent_dirty[slot_load]   <= 1'b0;
      end
      if (alloc_store) begin
        ent_command[slot_store] <= BUS_LOAD;  // fetch the block, merge at refill
        ent_issued[slot_store]  <= 1'b0;
        ent_dirty[slot_store]   <= 1'b1;
      end
      if (alloc_wb) begin
        ent_command[slot_wb] <= BUS_STORE;
        ent_issued[slot_wb]  <= 1'b0;
        ent_dirty[slot_wb]   <= 1'b0;
      end
      tail  <= slot_wb + mshr_ptr_w'(alloc_wb);
      count <= count + (mshr_ptr_w+1)'(alloc_load) + (mshr_ptr_w+1)'(alloc_store) +
               (mshr_ptr_w+1)'(alloc_wb) - (mshr_ptr_w+1)'(do_retire);
    end
  end

  // entry payload
  always_ff @(posedge clock) begin
    if (do_issue) ent_tag[issue] <= mem_response;
    if (alloc_load) begin
      ent_block[slot_load]     <= load_addr[addr_w-1:offset_w];
      ent_data[slot_load]      <= '0;
      ent_mask[slot_load]      <= '0;
      ent_offset[slot_load]    <= load_addr[offset_w-1];
      ent_from_load[slot_load] <= 1'b1;
    end
    if (alloc_store) begin
      ent_block[slot_store]     <= store_addr[addr_w-1:offset_w];
      ent_data[slot_store]      <= store_line;
      ent_mask[slot_store]      <= store_mask;
      ent_offset[slot_store]    <= store_addr[offset_w-1];
      ent_from_load[slot_store] <= 1'b0;
    end
    if (alloc_wb) begin
      ent_block[slot_wb]     <= victim_addr[addr_w-1:offset_w];
      ent_data[slot_wb]      <= victim_line;
      ent_mask[slot_wb]      <= '0;
      ent_offset[slot_wb]    <= 1'b0;
      ent_from_load[slot_wb] <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- design/dcache.sv
`timescale 1ns/100ps
`default_nettype none

module dcache import dcache_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  // load port
  input  logic                 load_start,
  input  logic [addr_w-1:0]    load_addr,
  output logic                 load_hit,
  output logic [word_w-1:0]    load_data,
  output logic                 load_stall,
  // load miss completion
  output logic                 broadcast_valid,
  output logic [word_w-1:0]    broadcast_data,
  // store port
  input  logic                 store_valid,
  input  logic [addr_w-1:0]    store_addr,
  input  logic [word_w-1:0]    store_data,
  input  logic [word_w/8-1:0]  store_bytes,
  output logic                 store_stall,
  // memory controller
  output bus_command_e         mem_command,
  output logic [addr_w-1:0]    mem_addr,
  output logic [line_w-1:0]    mem_data,
  input  logic [mem_tag_w-1:0] mem_response,
  input  logic [line_w-1:0]    mem_resp_data,
  input  logic [mem_tag_w-1:0] mem_resp_tag
);

  cache_line_u               rd_line;
  logic                      rd_valid;
  logic                      load_miss;
  logic                      store_miss;
  cache_line_u               store_line;
  logic [bytes_per_line-1:0] store_mask;
  logic                      refill_valid;
  logic [index_w-1:0]        refill_index;
  logic [tag_w-1:0]          refill_tag;
  cache_line_u               refill_line;
  logic                      refill_dirty;
  logic                      victim_valid;
  logic [addr_w-1:0]         victim_addr;
  cache_line_u               victim_line;
  logic [mshr_depth-1:0]     pending_store_hit;
  logic                      retire_load;
  cache_line_u               retire_line;
  logic                      retire_offset;

  dcache_array i_array (
    .clock        (clock),
    .reset        (reset),
    .load_addr    (load_addr),
    .rd_line      (rd_line),
    .rd_valid     (rd_valid),
    .store_valid  (store_valid),
    .store_addr   (store_addr),
    .store_data   (store_data),
    .store_bytes  (store_bytes),
    .store_miss   (store_miss),
    .store_line   (store_line),
    .store_mask   (store_mask),
    .refill_valid (refill_valid),
    .refill_index (refill_index),
    .refill_tag   (refill_tag),
    .refill_line  (refill_line),
    .refill_dirty (refill_dirty),
    .victim_valid (victim_valid),
    .victim_addr  (victim_addr),
    .victim_line  (victim_line)
  );

  dcache_load_port i_load_port (
    .clock             (clock),
    .reset             (reset),
    .load_start        (load_start),
    .load_addr         (load_addr),
    .rd_line           (rd_line),
    .rd_valid          (rd_valid),
    .pending_store_hit (pending_store_hit),
    .retire_load       (retire_load),
    .retire_line       (retire_line),
    .retire_offset     (retire_offset),
    .load_hit          (load_hit),
    .load_data         (load_data),
    .load_miss         (load_miss),
    .broadcast_valid   (broadcast_valid),
    .broadcast_data    (broadcast_data)
  );

  dcache_miss_queue i_miss_queue (
    .clock             (clock),
    .reset             (reset),
    .load_miss         (load_miss),
    .load_addr         (load_addr),
    .store_miss        (store_miss),
    .store_addr        (store_addr),
    .store_line        (store_line),
    .store_mask        (store_mask),
    .victim_valid      (victim_valid),
    .victim_addr       (victim_addr),
    .victim_line       (victim_line),
    .mem_response      (mem_response),
    .mem_resp_data     (mem_resp_data),
    .mem_resp_tag      (mem_resp_tag),
    .pending_store_hit (pending_store_hit),
    .load_stall        (load_stall),
    .store_stall       (store_stall),
    .refill_valid      (refill_valid),
    .refill_index      (refill_index),
    .refill_tag        (refill_tag),
    .refill_line       (refill_line),
    .refill_dirty      (refill_dirty),
    .retire_load       (retire_load),
    .retire_line       (retire_line),
    .retire_offset     (retire_offset),
    .mem_command       (mem_command),
    .mem_addr          (mem_addr),
    .mem_data          (mem_data)
  );

endmodule

`default_nettype wire

//--- dv/dcache_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_mem_model import dcache_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  bus_command_e         mem_command,
  input  logic [addr_w-1:0]    mem_addr,
  input  logic [line_w-1:0]    mem_data,
  output logic [mem_tag_w-1:0] mem_response,
  output logic [line_w-1:0]    mem_resp_data,
  output logic [mem_tag_w-1:0] mem_resp_tag
);

  localparam int latency = 3;

  logic [7:0]           shadow [2**addr_w];  // byte store, little endian
  logic [mem_tag_w-1:0] next_tag;
  int                   wait_cnt;
  int                   cycle;
  logic [mem_tag_w-1:0] ret_tag  [$];
  logic [line_w-1:0]    ret_data [$];
  int                   ret_due  [$];

  initial begin
    logic [31:0] word;
    for (int a = 0; a < 2**addr_w; a += 4) begin
      word = a ^ 32'h5c7f0000;
      for (int j = 0; j < 4; j++) shadow[a+j] = word[8*j +: 8];
    end
    mem_response  = '0;
    mem_resp_data = '0;
    mem_resp_tag  = '0;
  end

  always @(negedge clock) begin
    logic [line_w-1:0] line;
    if (reset) begin
      mem_response  <= '0;
      mem_resp_data <= '0;
      mem_resp_tag  <= '0;
      next_tag      = 1;
      wait_cnt      = 0;
      cycle         = 0;
    end else begin
      cycle++;
      mem_response  <= '0;
      mem_resp_tag  <= '0;
      mem_resp_data <= '0;
      // a command just accepted is gone from the bus by now
      if (mem_response == '0 && mem_command != BUS_NONE) begin
        if (wait_cnt == latency - 1) begin
          mem_response <= next_tag;
          if (mem_command == BUS_STORE) begin
            for (int j = 0; j < 8; j++) shadow[mem_addr + j] = mem_data[8*j +: 8];
          end else begin
            for (int j = 0; j < 8; j++) line[8*j +: 8] = shadow[mem_addr + j];
            ret_tag.push_back(next_tag);
            ret_data.push_back(line);
            ret_due.push_back(cycle + latency);
          end
          next_tag = (next_tag == 4'hf) ? 4'h1 : next_tag + 1'b1;  // never zero
          wait_cnt = 0;
        end else begin
          wait_cnt++;
        end
      end
      if (ret_due.size() > 0 && ret_due[0] <= cycle) begin
        mem_resp_tag  <= ret_tag.pop_front();
        mem_resp_data <= ret_data.pop_front();
        void'(ret_due.pop_front());
      end
    end
  end

endmodule

`default_nettype wire

//--- dv/dcache_checker.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_checker import dcache_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 load_start,
  input  logic [addr_w-1:0]    load_addr,
  input  logic                 load_hit,
  input  logic [word_w-1:0]    load_data,
  input  logic                 load_stall,
  input  logic                 load_miss,
  input  logic                 broadcast_valid,
  input  logic [word_w-1:0]    broadcast_data,
  input  logic                 store_valid,
  input  logic [addr_w-1:0]    store_addr,
  input  logic [word_w-1:0]    store_data,
  input  logic [3:0]           store_bytes,
  input  logic                 store_stall,
  input  bus_command_e         mem_command,
  input  logic [addr_w-1:0]    mem_addr,
  input  logic [line_w-1:0]    mem_data,
  input  logic [mem_tag_w-1:0] mem_response,
  input  logic                 exp_hit,
  input  logic                 row_done,
  input  int                   row_num,
  output int                   rows_passed,
  output int                   rows_failed,
  output int                   outstanding,
  output int                   wb_count,
  output logic                 stall_seen
);

  logic [7:0]        ref_mem [2**addr_w];
  logic [word_w-1:0] pending [$];  // expected broadcast words, oldest first
  int                row_errors;
  logic              reset_q;

  initial begin
    logic [31:0] word;
    for (int a = 0; a < 2**addr_w; a += 4) begin
      word = a ^ 32'h5c7f0000;
      for (int j = 0; j < 4; j++) ref_mem[a+j] = word[8*j +: 8];
    end
    rows_passed = 0;
    rows_failed = 0;
    wb_count    = 0;
    row_errors  = 0;
    stall_seen  = 1'b0;
  end

  function automatic logic [word_w-1:0] ref_word(input logic [addr_w-1:0] a);
    logic [addr_w-1:0] base;
    base = {a[addr_w-1:2], 2'b00};
    return {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
  endfunction

  function automatic logic [line_w-1:0] ref_line(input logic [addr_w-1:0] a);
    logic [line_w-1:0] l;
    for (int j = 0; j < 8; j++) l[8*j +: 8] = ref_mem[{a[addr_w-1:3], 3'b000} + j];
    return l;
  endfunction

  task automatic fail(input string msg);
    $display("FAILED %0t: %s", $time, msg);
    row_errors++;
  endtask

  assign outstanding = pending.size();

  always @(posedge clock) begin
    logic [addr_w-1:0] base;
    reset_q <= reset;
    if (!reset) begin
      if (reset_q) begin
        if (mem_command != BUS_NONE) fail("mem_command not idle after reset");
        if (load_stall || store_stall) fail("stall high after reset");
        if (broadcast_valid) fail("broadcast_valid high after reset");
      end
      // only a stall with loads in flight counts
      if ((load_stall || store_stall) && pending.size() != 0) stall_seen <= 1'b1;
      // compare before this edge's store lands
      if (load_start) begin
        if (load_hit !== exp_hit) begin
          fail($sformatf("load 0x%h hit %b expected %b", load_addr, load_hit, exp_hit));
        end
        if (load_hit && load_data !== ref_word(load_addr)) begin
          fail($sformatf("load 0x%h data %h expected %h", load_addr, load_data,
                         ref_word(load_addr)));
        end
      end
      if (load_miss && !load_stall) pending.push_back(ref_word(load_addr));
      if (broadcast_valid) begin
        if (pending.size() == 0) begin
          fail("broadcast with no load miss outstanding");
        end else if (broadcast_data !== pending[0]) begin
          fail($sformatf("broadcast data %h expected %h", broadcast_data, pending[0]));
          void'(pending.pop_front());
        end else begin
          void'(pending.pop_front());
        end
      end
      if (mem_command == BUS_STORE && mem_response != '0) begin
        wb_count <= wb_count + 1;
        if (mem_data !== ref_line(mem_addr)) begin
          fail($sformatf("writeback 0x%h data %h expected %h", mem_addr, mem_data,
                         ref_line(mem_addr)));
        end
      end
      // mirror every accepted store
      if (store_valid && !store_stall) begin
        base = {store_addr[addr_w-1:2], 2'b00};
        for (int j = 0; j < 4; j++) begin
          if (store_bytes[j]) ref_mem[base+j] = store_data[8*j +: 8];
        end
      end
      if (row_done) begin
        if (row_errors == 0) begin
          rows_passed <= rows_passed + 1;
          $display("row %0d passed", row_num);
        end else begin
          rows_failed <= rows_failed + 1;
          $display("row %0d failed with %0d errors", row_num, row_errors);
        end
        row_errors = 0;
      end
    end
  end

endmodule

`default_nettype wire

//--- dv/dcache_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_assertions import dcache_pkg::*; (
  input logic                  clock,
  input logic                  reset,
  input bus_command_e          mem_command,
  input logic [addr_w-1:0]     mem_addr,
  input logic [mem_tag_w-1:0]  mem_response,
  input logic                  load_miss,
  input logic                  load_stall,
  input logic                  store_stall,
  input logic                  victim_valid,
  input logic [mshr_ptr_w-1:0] tail,
  input logic [mshr_ptr_w:0]   count
);

  int fail_count;

  initial fail_count = 0;

  // back-pressure holds the command
  cmd_held: assert property (@(posedge clock) disable iff (reset)
    (mem_command != BUS_NONE && mem_response == '0) |=>
      (mem_command == $past(mem_command) && mem_addr == $past(mem_addr)))
    else begin
      fail_count++;
      $error("command changed before it was accepted");
    end

  // load_stall implies store_stall, so only a writeback may enter
  load_alloc_ok: assert property (@(posedge clock) disable iff (reset)
    (load_stall && !victim_valid) |=> $stable(tail))
    else begin
      fail_count++;
      $error("load allocated while load_stall high");
    end

  store_alloc_ok: assert property (@(posedge clock) disable iff (reset)
    (store_stall && !load_miss && !victim_valid) |=> $stable(tail))
    else begin
      fail_count++;
      $error("store allocated while store_stall high");
    end

  tail_behind_head: assert property (@(posedge clock) disable iff (reset)
    count <= (mshr_ptr_w+1)'(mshr_depth))
    else begin
      fail_count++;
      $error("tail passed the head");
    end

endmodule

bind dcache_miss_queue dcache_assertions i_assertions (
  .clock        (clock),
  .reset        (reset),
  .mem_command  (mem_command),
  .mem_addr     (mem_addr),
  .mem_response (mem_response),
  .load_miss    (load_miss),
  .load_stall   (load_stall),
  .store_stall  (store_stall),
  .victim_valid (victim_valid),
  .tail         (tail),
  .count        (count)
);

`default_nettype wire

//--- dv/dcache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_tb import dcache_pkg::*; ();

  localparam int op_load  = 0;  // waits for broadcast on a miss
  localparam int op_store = 1;
  localparam int op_burst = 2;  // load that does not wait
  localparam int op_drain = 3;
  localparam int max_rows = 48;
  localparam int timeout  = 400;

  logic                 clock;
  logic                 reset;
  logic                 load_start;
  logic [addr_w-1:0]    load_addr;
  logic                 load_hit;
  logic [word_w-1:0]    load_data;
  logic                 load_stall;
  logic                 broadcast_valid;
  logic [word_w-1:0]    broadcast_data;
  logic                 store_valid;
  logic [addr_w-1:0]    store_addr;
  logic [word_w-1:0]    store_data;
  logic [3:0]           store_bytes;
  logic                 store_stall;
  bus_command_e         mem_command;
  logic [addr_w-1:0]    mem_addr;
  logic [line_w-1:0]    mem_data;
  logic [mem_tag_w-1:0] mem_response;
  logic [line_w-1:0]    mem_resp_data;
  logic [mem_tag_w-1:0] mem_resp_tag;
  logic                 exp_hit;
  logic                 row_done;
  int                   row_num;
  int                   rows_passed;
  int                   rows_failed;
  int                   outstanding;
  int                   wb_count;
  logic                 stall_seen;

  // stimulus table
  int                row_op   [max_rows];
  logic [addr_w-1:0] row_addr [max_rows];
  logic [word_w-1:0] row_data [max_rows];
  logic [3:0]        row_mask [max_rows];
  logic              row_hit  [max_rows];
  int                n_rows;
  int                tb_errors;

  always #2 clock = ~clock;

  dcache i_dcache (.*);

  dcache_mem_model i_mem_model (.*);

  dcache_checker i_checker (
    .load_miss (i_dcache.load_miss),
    .*
  );

  task automatic add_row(input int op, input logic [addr_w-1:0] addr,
                         input logic [word_w-1:0] data, input logic [3:0] mask,
                         input logic hit);
    row_op[n_rows]   = op;
    row_addr[n_rows] = addr;
    row_data[n_rows] = data;
    row_mask[n_rows] = mask;
    row_hit[n_rows]  = hit;
    n_rows++;
  endtask

  task automatic build_table();
    logic [addr_w-1:0] burst_addr [12];
    add_row(op_load, 16'h1234, '0, '0, 1'b0);        // cold miss
    add_row(op_load, 16'h1234, '0, '0, 1'b1);
    add_row(op_store, 16'h1230, $urandom, 4'b0101, 1'b1);
    add_row(op_load, 16'h1230, '0, '0, 1'b1);
    add_row(op_store, 16'h2418, $urandom, 4'b0011, 1'b0);
    add_row(op_load, 16'h2418, '0, '0, 1'b0);        // blocked by the store miss
    add_row(op_load, 16'h2418, '0, '0, 1'b1);
    add_row(op_load, 16'h5630, '0, '0, 1'b0);        // same index, evicts dirty line
    add_row(op_load, 16'h1230, '0, '0, 1'b0);
    add_row(op_load, 16'h1234, '0, '0, 1'b1);
    for (int k = 0; k < 12; k++) begin
      burst_addr[k] = {8'h90 + 8'($urandom % 8'h60), 5'(k + 8), 1'($urandom), 2'b00};
      if (k % 4 == 3) begin
        add_row(op_store, burst_addr[k], $urandom, 4'($urandom), 1'b0);
      end else begin
        add_row(op_burst, burst_addr[k], '0, '0, 1'b0);
      end
    end
    add_row(op_drain, '0, '0, '0, 1'b0);
    for (int k = 0; k < 12; k++) add_row(op_load, burst_addr[k], '0, '0, 1'b1);
  endtask

  // called on a falling edge
  task automatic wait_ready(input int op);
    int n;
    n = 0;
    while ((op == op_store) ? store_stall : load_stall) begin
      if (n == timeout) begin
        $display("timeout waiting for stall to clear");
        tb_errors++;
        break;
      end
      n++;
      @(negedge clock);
    end
  endtask

  task automatic wait_done(input logic want_broadcast);
    int n;
    n = 0;
    forever begin
      @(posedge clock);
      if (want_broadcast && broadcast_valid) break;
      if (i_dcache.i_miss_queue.count == 0) break;
      if (n == timeout) begin
        if (want_broadcast) $display("timeout waiting for broadcast");
        else $display("timeout waiting for queue to drain");
        tb_errors++;
        break;
      end
      n++;
    end
    @(negedge clock);
  endtask

  task automatic run_row(input int i);
    wait_ready(row_op[i]);
    exp_hit = row_hit[i];
    if (row_op[i] == op_load || row_op[i] == op_burst) begin
      load_start = 1'b1;
      load_addr  = row_addr[i];
    end else if (row_op[i] == op_store) begin
      store_valid = 1'b1;
      store_addr  = row_addr[i];
      store_data  = row_data[i];
      store_bytes = row_mask[i];
    end
    @(negedge clock);
    load_start  = 1'b0;
    store_valid = 1'b0;
    if (row_op[i] == op_load && !row_hit[i]) wait_done(1'b1);
    if (row_op[i] == op_drain) wait_done(1'b0);
    row_num  = i;
    row_done = 1'b1;
    @(negedge clock);
    row_done = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h5c7fb48a));
    clock       = 1'b0;
    reset       = 1'b1;
    load_start  = 1'b0;
    load_addr   = '0;
    store_valid = 1'b0;
    store_addr  = '0;
    store_data  = '0;
    store_bytes = '0;
    exp_hit     = 1'b0;
    row_done    = 1'b0;
    row_num     = 0;
    n_rows      = 0;
    tb_errors   = 0;
    build_table();
    repeat (16) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    for (int i = 0; i < n_rows; i++) run_row(i);
    wait_done(1'b0);
    if (outstanding != 0) begin
      $display("loads still waiting for broadcast: %0d", outstanding);
      tb_errors++;
    end
    if (wb_count == 0) begin
      $display("no writeback of the dirty victim seen");
      tb_errors++;
    end
    if (!stall_seen) begin
      $display("no stall seen during the miss burst");
      tb_errors++;
    end
    if (i_dcache.i_miss_queue.i_assertions.fail_count != 0) begin
      $display("miss queue protocol assertions failed: %0d",
               i_dcache.i_miss_queue.i_assertions.fail_count);
      tb_errors += i_dcache.i_miss_queue.i_assertions.fail_count;
    end
    $display("rows passed %0d, rows failed %0d, other errors %0d",
             rows_passed, rows_failed, tb_errors);
    if (rows_failed == 0 && tb_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dcache.f
design/dcache_pkg.sv
design/dcache_array.sv
design/dcache_load_port.sv
design/dcache_miss_queue.sv
design/dcache.sv
dv/dcache_mem_model.sv
dv/dcache_checker.sv
dv/dcache_assertions.sv
dv/dcache_tb.sv
